// File: all.f
+incdir+hdl
hdl/conv_pkg.sv
hdl/conv_ram.sv
hdl/conv_data_mover.sv
hdl/conv_pe_array.sv
hdl/conv_top.sv
sim/conv_asserts.sv
sim/conv_tb.sv

// File: sim/conv_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module conv_tb
    import conv_pkg::*;
();

    localparam int PAIRS          = `CONV_FEAT_DEPTH * `CONV_FILT_DEPTH;
    localparam int READS_PER_RUN  = `CONV_FEAT_DEPTH * (`CONV_FILT_DEPTH + 1);
    localparam int RUNS           = 7;
    localparam int TIMEOUT_CYCLES = RUNS * READS_PER_RUN * 2 + 500;  // Slack for loads, pauses

    logic clk, rst_n, start, en, wr_en, wr_sel;
    logic [`CONV_FEAT_AW-1:0] wr_addr;
    feat_vec_t wr_data;
    logic busy, done, result_valid;
    acc_t result_data;
    feat_idx_t result_feat;
    filt_idx_t result_filt;

    feat_vec_t feat_model [`CONV_FEAT_DEPTH];
    wgt_vec_t  wgt_model [`CONV_FILT_DEPTH];
    acc_t      exp_data [$];
    feat_idx_t exp_feat [$];
    filt_idx_t exp_filt [$];
    logic [31:0] lcg_state = 32'h4e60;
    int err_count, pass_tests, fail_tests, result_count, done_count, cycle_count;

    conv_top conv_top_i (
        .clk (clk), .rst_n (rst_n), .start (start), .en (en),
        .wr_en (wr_en), .wr_sel (wr_sel), .wr_addr (wr_addr), .wr_data (wr_data),
        .busy (busy), .done (done), .result_valid (result_valid),
        .result_data (result_data), .result_feat (result_feat), .result_filt (result_filt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout, run still going after %0d cycles", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic feat_vec_t random_vec();
        feat_vec_t v;
        for (int i = 0; i < `CONV_PE_SIZE; i++) begin
            v[i] = lane_t'(lcg_next() >> 16);  // Upper bits of the LCG
        end
        return v;
    endfunction

    function automatic feat_vec_t fill_vec(input lane_t value);
        feat_vec_t v;
        for (int i = 0; i < `CONV_PE_SIZE; i++) begin
            v[i] = value;
        end
        return v;
    endfunction

    // Dot product of one feature word and one filter word
    function automatic acc_t ref_dot(input int f, input int w);
        int sum;
        sum = 0;
        for (int i = 0; i < `CONV_PE_SIZE; i++) begin
            sum += int'(feat_model[f][i]) * int'(wgt_model[w][i]);
        end
        return acc_t'(sum);
    endfunction

    task automatic compare_acc(input string name, input acc_t got, input acc_t exp);
        if (got !== exp) begin
            err_count++;
            $display("FAILED t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_idx(input string name, input feat_idx_t got_f, input filt_idx_t got_w,
                               input feat_idx_t exp_f, input filt_idx_t exp_w);
        if ({got_f, got_w} !== {exp_f, exp_w}) begin
            err_count++;
            $display("FAILED t=%0t %s: got (%0d,%0d), expected (%0d,%0d)",
                     $time, name, got_f, got_w, exp_f, exp_w);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_count++;
            $display("FAILED t=%0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        err_count++;
        $display("Error at t=%0t: %s", $time, msg);
    endtask

    // Results checked in arrival order
    always @(negedge clk) begin
        if (rst_n && done) done_count++;
        if (rst_n && result_valid) begin
            result_count++;
            if (exp_data.size() == 0) begin
                report_error("result arrived with no result outstanding");
            end else begin
                compare_acc("result_data", result_data, exp_data.pop_front());
                compare_idx("result_feat/result_filt", result_feat, result_filt,
                            exp_feat.pop_front(), exp_filt.pop_front());
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_write(input logic sel, input int addr, input feat_vec_t data);
        wr_en   = 1'b1;
        wr_sel  = sel;
        wr_addr = addr[`CONV_FEAT_AW-1:0];
        wr_data = data;
        next_cycle();
        wr_en   = 1'b0;
    endtask

    task automatic write_word(input logic sel, input int addr, input feat_vec_t data);
        drive_write(sel, addr, data);
        if (sel) wgt_model[addr] = wgt_vec_t'(data);
        else feat_model[addr] = data;
    endtask

    task automatic load_random();
        for (int a = 0; a < `CONV_FEAT_DEPTH; a++) begin
            write_word(1'b0, a, random_vec());
            write_word(1'b1, a, random_vec());
        end
    endtask

    // Feature-major, filter-minor
    task automatic begin_run();
        result_count = 0;
        done_count   = 0;
        for (int f = 0; f < `CONV_FEAT_DEPTH; f++) begin
            for (int w = 0; w < `CONV_FILT_DEPTH; w++) begin
                exp_data.push_back(ref_dot(f, w));
                exp_feat.push_back(feat_idx_t'(f));
                exp_filt.push_back(filt_idx_t'(w));
            end
        end
        start = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    task automatic finish_run(input bit pause);
        bit seen;
        int pause_left;
        seen = 1'b0;
        pause_left = 0;
        while (!seen) begin
            @(negedge clk);
            seen = done;
            if (!seen) begin
                next_cycle();
                if (pause_left > 0) pause_left--;
                else if (pause && lcg_next() % 6 == 0) pause_left = 1 + lcg_next() % 4;
                en = (pause_left == 0);
            end
        end
        compare_bit("busy", busy, 1'b0);  // Falls with done
        if (result_count != PAIRS)
            report_error($sformatf("done came after %0d results, not %0d", result_count, PAIRS));
        next_cycle();
        en = 1'b1;
        repeat (8) @(negedge clk);
        compare_bit("done", done, 1'b0);
        compare_bit("busy", busy, 1'b0);
        if (done_count != 1) report_error($sformatf("done pulsed %0d times", done_count));
        if (exp_data.size() != 0)
            report_error($sformatf("%0d expected results never arrived", exp_data.size()));
        next_cycle();
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            pass_tests++;
            $display("%s: passed", name);
        end else begin
            fail_tests++;
            $display("%s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic test_basic_run();
        int errs;
        errs = err_count;
        compare_bit("busy", busy, 1'b0);
        compare_bit("done", done, 1'b0);
        compare_bit("result_valid", result_valid, 1'b0);
        load_random();
        begin_run();
        finish_run(1'b0);
        end_test("basic_run", errs);
    endtask

    task automatic test_pause();
        int errs;
        errs = err_count;
        begin_run();
        finish_run(1'b1);
        end_test("pause", errs);
    endtask

    task automatic test_extreme();
        int errs;
        errs = err_count;
        for (int a = 0; a < `CONV_FEAT_DEPTH; a++) begin
            write_word(1'b0, a, fill_vec(lane_t'(-128)));
            write_word(1'b1, a, fill_vec(lane_t'(-128)));
        end
        begin_run();
        finish_run(1'b0);
        for (int a = 0; a < `CONV_FILT_DEPTH; a++) write_word(1'b1, a, fill_vec(lane_t'(127)));
        begin_run();
        finish_run(1'b0);
        end_test("extreme_operands", errs);
    endtask

    task automatic test_blocked();
        int errs;
        errs = err_count;
        load_random();
        begin_run();
        for (int a = 0; a < `CONV_FEAT_DEPTH; a++) begin
            drive_write(1'b0, a, random_vec());  // Dropped while busy
            drive_write(1'b1, a, random_vec());
        end
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        finish_run(1'b0);
        end_test("blocked_writes", errs);
    endtask

    task automatic test_back_to_back();
        int errs;
        errs = err_count;
        begin_run();
        finish_run(1'b0);
        for (int a = 0; a < `CONV_FILT_DEPTH; a++) write_word(1'b1, a, random_vec());
        begin_run();
        finish_run(1'b0);
        end_test("back_to_back", errs);
    endtask

    initial begin
        rst_n   = 1'b0;
        start   = 1'b0;
        en      = 1'b0;
        wr_en   = 1'b0;
        wr_sel  = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        en    = 1'b1;
        next_cycle();
        test_basic_run();
        test_pause();
        test_extreme();
        test_blocked();
        test_back_to_back();
        err_count += conv_top_i.mover_i.asserts_i.fail_count;
        $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
                 pass_tests, fail_tests, conv_top_i.mover_i.asserts_i.fail_count);
        if (fail_tests == 0 && err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/conv_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module conv_data_mover_asserts (
    input logic clk,
    input logic rst_n,
    input logic en,
    input logic feat_rd,
    input logic wgt_rd,
    input logic busy,
    input logic done
);

    int fail_count = 0;  // Tally of assertion failures

    a_rd_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(feat_rd && wgt_rd))
        else begin
            fail_count++;
            $error("feat_rd and wgt_rd high in the same cycle");
        end

    a_rd_needs_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> !(feat_rd || wgt_rd))
        else begin
            fail_count++;
            $error("Read strobe high while busy is low");
        end

    // One cycle only
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else begin
            fail_count++;
            $error("done held for more than one cycle");
        end

    a_no_rd_paused: assert property (@(posedge clk) disable iff (!rst_n)
        !en |-> !(feat_rd || wgt_rd))
        else begin
            fail_count++;
            $error("Read issued while en is low");
        end

endmodule

bind conv_data_mover conv_data_mover_asserts asserts_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .en      (en),
    .feat_rd (feat_rd),
    .wgt_rd  (wgt_rd),
    .busy    (busy),
    .done    (done)
);

`default_nettype wire

// File: hdl/conv_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module conv_top
    import conv_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic                     en,

    // Host write port, wr_sel 0 features, 1 weights
    input  logic                     wr_en,
    input  logic                     wr_sel,
    input  logic [`CONV_FEAT_AW-1:0] wr_addr,
    input  feat_vec_t                wr_data,

    output logic                     busy,
    output logic                     done,
    output logic                     result_valid,
    output acc_t                     result_data,
    output feat_idx_t                result_feat,
    output filt_idx_t                result_filt
);

    logic      feat_wr;
    logic      wgt_wr;
    logic      feat_rd;
    logic      wgt_rd;
    feat_idx_t feat_addr;
    filt_idx_t wgt_addr;
    feat_vec_t feat_q;
    wgt_vec_t  wgt_q;
    logic      feat_load;
    logic      wgt_issue;
    feat_idx_t issue_feat;
    filt_idx_t issue_filt;

    // Host writes dropped during a run
    assign feat_wr = wr_en && !wr_sel && !busy;
    assign wgt_wr  = wr_en && wr_sel && !busy;

    conv_ram #(
        .word_t (feat_vec_t),
        .depth  (`CONV_FEAT_DEPTH)
    ) feat_ram_i (
        .clk     (clk),
        .wr_en   (feat_wr),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (feat_rd),
        .rd_addr (feat_addr),
        .rd_data (feat_q)
    );

    conv_ram #(
        .word_t (wgt_vec_t),
        .depth  (`CONV_FILT_DEPTH)
    ) wgt_ram_i (
        .clk     (clk),
        .wr_en   (wgt_wr),
        .wr_addr (wr_addr),
        .wr_data (wgt_vec_t'(wr_data)),
        .rd_en   (wgt_rd),
        .rd_addr (wgt_addr),
        .rd_data (wgt_q)
    );

    conv_data_mover mover_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .en           (en),
        .result_valid (result_valid),
        .feat_rd      (feat_rd),
        .feat_addr    (feat_addr),
        .wgt_rd       (wgt_rd),
        .wgt_addr     (wgt_addr),
        .feat_load    (feat_load),
        .wgt_issue    (wgt_issue),
        .issue_feat   (issue_feat),
        .issue_filt   (issue_filt),
        .busy         (busy),
        .done         (done)
    );

    conv_pe_array pe_array_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .feat_load    (feat_load),
        .feat_data    (feat_q),
        .wgt_issue    (wgt_issue),
        .wgt_data     (wgt_q),
        .issue_feat   (issue_feat),
        .issue_filt   (issue_filt),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_feat  (result_feat),
        .result_filt  (result_filt)
    );

endmodule

`default_nettype wire

// File: hdl/conv_pe_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module conv_pe_array
    import conv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      feat_load,
    input  feat_vec_t feat_data,
    input  logic      wgt_issue,
    input  wgt_vec_t  wgt_data,
    input  feat_idx_t issue_feat,
    input  filt_idx_t issue_filt,

    output logic      result_valid,
    output acc_t      result_data,
    output feat_idx_t result_feat,
    output filt_idx_t result_filt
);

    localparam int PE     = `CONV_PE_SIZE;
    localparam int STAGES = `CONV_TREE_STAGES;
    localparam int NODES  = 2 * PE - 1;

    // Tree nodes packed level by level, products first, root last
    function automatic int level_base(input int lvl);
        return 2 * (PE - (PE >> lvl));
    endfunction

    feat_vec_t    feat_reg;
    acc_t         node [NODES];
    logic [STAGES:0] vld;           // Bit 0 is the product stage
    feat_idx_t    feat_tag [STAGES+1];
    filt_idx_t    filt_tag [STAGES+1];

    always_ff @(posedge clk) begin
        if (feat_load) begin
            feat_reg <= feat_data;
        end
    end

    always_ff @(posedge clk) begin
        if (wgt_issue) begin
            for (int i = 0; i < PE; i++) begin
                node[i] <= acc_t'(feat_reg[i]) * acc_t'(wgt_data[i]);  // Signed lane product
            end
        end
        // Pairwise sums, one level per stage
        for (int s = 1; s <= STAGES; s++) begin
            for (int j = 0; j < (PE >> s); j++) begin
                node[level_base(s) + j] <= node[level_base(s-1) + 2*j]
                                         + node[level_base(s-1) + 2*j + 1];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld <= '0;
        end else begin
            vld <= {vld[STAGES-1:0], wgt_issue};
        end
    end

    // Tags ride along with the tree
    always_ff @(posedge clk) begin
        feat_tag[0] <= issue_feat;
        filt_tag[0] <= issue_filt;
        for (int s = 1; s <= STAGES; s++) begin
            feat_tag[s] <= feat_tag[s-1];
            filt_tag[s] <= filt_tag[s-1];
        end
    end

    assign result_valid = vld[STAGES];
    assign result_data  = node[NODES-1];
    assign result_feat  = feat_tag[STAGES];
    assign result_filt  = filt_tag[STAGES];

endmodule

`default_nettype wire

// File: hdl/conv_data_mover.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module conv_data_mover
    import conv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  logic      en,
    input  logic      result_valid,

    output logic      feat_rd,
    output feat_idx_t feat_addr,
    output logic      wgt_rd,
    output filt_idx_t wgt_addr,

    output logic      feat_load,
    output logic      wgt_issue,
    output feat_idx_t issue_feat,
    output filt_idx_t issue_filt,

    output logic      busy,
    output logic      done
);

    localparam feat_idx_t FEAT_LAST = feat_idx_t'(`CONV_FEAT_DEPTH - 1);
    localparam filt_idx_t FILT_LAST = filt_idx_t'(`CONV_FILT_DEPTH - 1);
    localparam int        PEND_W    = $clog2(`CONV_TREE_STAGES + 3);

    logic              issuing;    // Reads still to go
    logic              wgt_phase;  // 0 feature read, 1 weight sweep
    feat_idx_t         feat_cnt;
    filt_idx_t         filt_cnt;
    logic [PEND_W-1:0] pending;    // Weight reads without a result yet
    logic              can_issue;

    assign can_issue = busy && issuing && en;
    assign feat_rd   = can_issue && !wgt_phase;
    assign wgt_rd    = can_issue && wgt_phase;
    assign feat_addr = feat_cnt;
    assign wgt_addr  = filt_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            issuing   <= 1'b0;
            wgt_phase <= 1'b0;
            feat_cnt  <= '0;
            filt_cnt  <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy      <= 1'b1;
                    issuing   <= 1'b1;
                    wgt_phase <= 1'b0;
                    feat_cnt  <= '0;
                    filt_cnt  <= '0;
                end
            end else begin
                if (feat_rd) begin
                    wgt_phase <= 1'b1;
                end else if (wgt_rd) begin
                    if (filt_cnt == FILT_LAST) begin
                        filt_cnt  <= '0;
                        wgt_phase <= 1'b0;
                        if (feat_cnt == FEAT_LAST) begin
                            issuing <= 1'b0;  // Final weight read
                        end else begin
                            feat_cnt <= feat_cnt + 1'b1;
                        end
                    end else begin
                        filt_cnt <= filt_cnt + 1'b1;
                    end
                end
                // Last result back
                if (!issuing && result_valid && pending == PEND_W'(1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            case ({wgt_rd, result_valid})
                2'b10:   pending <= pending + 1'b1;
                2'b01:   pending <= pending - 1'b1;
                default: pending <= pending;
            endcase
        end
    end

    // Strobes line up with buffer read data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            feat_load <= 1'b0;
            wgt_issue <= 1'b0;
        end else begin
            feat_load <= feat_rd;
            wgt_issue <= wgt_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (wgt_rd) begin
            issue_feat <= feat_cnt;
            issue_filt <= filt_cnt;
        end
    end

endmodule

`default_nettype wire

// File: hdl/conv_ram.sv
`timescale 1ns/10ps
`default_nettype none

module conv_ram #(
    parameter type word_t = logic [7:0],
    parameter int  depth  = 8
) (
    input  logic                     clk,

    // Host side
    input  logic                     wr_en,
    input  logic [$clog2(depth)-1:0] wr_addr,
    input  word_t                    wr_data,

    // Mover side
    input  logic                     rd_en,
    input  logic [$clog2(depth)-1:0] rd_addr,
    output word_t                    rd_data
);

    word_t mem [depth];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, data one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: hdl/conv_pkg.sv
`default_nettype none

`include "conv_macros.svh"

package conv_pkg;

    // One signed operand lane
    typedef logic signed [`CONV_DATA_W-1:0] lane_t;

    // Activation word, lane 0 in the low bits
    typedef lane_t [`CONV_PE_SIZE-1:0] feat_vec_t;

    // Filter word, same layout as the activation word
    typedef lane_t [`CONV_PE_SIZE-1:0] wgt_vec_t;

    typedef logic signed [`CONV_ACC_W-1:0] acc_t;  // Dot product

    typedef logic [`CONV_FEAT_AW-1:0] feat_idx_t;
    typedef logic [`CONV_FILT_AW-1:0] filt_idx_t;

endpackage

`default_nettype wire

// File: hdl/conv_macros.svh
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// PE array geometry
`define CONV_PE_SIZE     16
`define CONV_DATA_W      8
`define CONV_ACC_W       32

// Operand buffer sizes
`define CONV_FEAT_DEPTH  8
`define CONV_FILT_DEPTH  8
`define CONV_FEAT_AW     3
`define CONV_FILT_AW     3

// Register stages in the adder tree, log2 of lane count
`define CONV_TREE_STAGES 4

`endif
